// File: design/mp3_dec_defines.svh
// MP3 decoder constants
`ifndef MP3_DEC_DEFINES_SVH
`define MP3_DEC_DEFINES_SVH

// ====================
// datapath widths
// ====================

// fifo word and sample width
`define MP3_DATA_WIDTH 16

// samples per channel per granule, cut down from 576
`define MP3_GRANULE_LEN 8

// buffer address, enough for one granule
`define MP3_ADDR_WIDTH 3

// ====================
// header word layout
// ====================

// channel mode field
`define MP3_HDR_MODE_MSB 15
`define MP3_HDR_MODE_LSB 14

// per channel block info, four bits each
`define MP3_HDR_CH1_LSB 4
`define MP3_HDR_CH0_LSB 0

`endif

// File: design/mp3_dec_pkg.sv
// MP3 decoder types
`include "mp3_dec_defines.svh"

package mp3_dec_pkg;

	// ====================
	// header fields
	// ====================

	// channel mode as coded in the frame header
	typedef enum logic [1:0] {
		stereo       = 2'd0,
		joint_stereo = 2'd1,
		dual_channel = 2'd2,
		mono         = 2'd3
	} channel_mode_e;

	// block info of one channel, msb first as in the header
	typedef struct packed {
		logic       switching;
		logic [1:0] block_type;
		logic       mixed_block;
	} side_info_t;

	// everything the mac stage needs for one granule
	typedef struct packed {
		channel_mode_e mode;
		side_info_t    ch0;
		side_info_t    ch1;
	} granule_info_t;

	// ====================
	// datapath words
	// ====================

	// reader to both channel buffers, shared address and data
	typedef struct packed {
		logic                        ch0_we;
		logic                        ch1_we;
		logic [`MP3_ADDR_WIDTH-1:0]  addr;
		logic [`MP3_DATA_WIDTH-1:0]  data;
	} buf_write_t;

	// one output sample with its tags
	typedef struct packed {
		logic                        channel;
		logic [`MP3_ADDR_WIDTH-1:0]  index;
		side_info_t                  info;
		logic [`MP3_DATA_WIDTH-1:0]  sample;
	} pcm_word_t;

endpackage

// File: design/reset_sequencer.sv
// Core reset sequencer
module reset_sequencer (
	input  logic master_clock,
	input  logic MAC_resetn,
	input  logic module_en,
	output logic core_resetn
);

	// first stage, set one edge after reset release
	logic ready_q;
	// second stage, ready gated by the enable
	logic core_q;

	// both stages clear at once with the board reset
	always_ff @(posedge master_clock or negedge MAC_resetn) begin
		if (!MAC_resetn) begin
			ready_q <= 1'b0;
			core_q  <= 1'b0;
		end else begin
			ready_q <= 1'b1;
			// enable low pulls the core into reset on the next edge
			core_q  <= ready_q & module_en;
		end
	end

	// single flop drives the core reset, so no glitch on the net
	assign core_resetn = core_q;

endmodule

// File: design/huff_stream_reader.sv
// Granule stream reader
`include "mp3_dec_defines.svh"

module huff_stream_reader (
	input  logic                          master_clock,
	input  logic                          core_resetn,
	input  logic                          fifo_empty,
	input  logic [`MP3_DATA_WIDTH-1:0]    fifo_data,
	output logic                          fifo_rd,
	input  logic                          huff_req,
	output logic                          huff_ack,
	output mp3_dec_pkg::granule_info_t    info,
	output mp3_dec_pkg::buf_write_t       buf_wr
);

	localparam logic [`MP3_ADDR_WIDTH-1:0] last_idx = `MP3_ADDR_WIDTH'(`MP3_GRANULE_LEN - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_header,
		st_samples,
		st_ack
	} rd_state_e;

	rd_state_e                   state;
	// sample index inside the granule
	logic [`MP3_ADDR_WIDTH-1:0]  idx;
	// channel of the next sample word
	logic                        ch;
	// decoded header, held through the ack
	mp3_dec_pkg::granule_info_t  info_q;
	logic                        two_ch;
	logic                        last_word;

	// ====================
	// word decode
	// ====================

	// channel 1 words only follow for stereo and joint stereo
	assign two_ch = (info_q.mode == mp3_dec_pkg::stereo) ||
		(info_q.mode == mp3_dec_pkg::joint_stereo);

	// last index, and channel 1 done if present
	assign last_word = (idx == last_idx) && (ch || !two_ch);

	// pop only in the read states, never from an empty fifo
	assign fifo_rd = ((state == st_header) || (state == st_samples)) && !fifo_empty;

	assign huff_ack = (state == st_ack);
	assign info = info_q;

	// sample words go straight to the buffer of their channel
	always_comb begin
		buf_wr.ch0_we = fifo_rd && (state == st_samples) && !ch;
		buf_wr.ch1_we = fifo_rd && (state == st_samples) && ch;
		buf_wr.addr = idx;
		buf_wr.data = fifo_data;
	end

	// ====================
	// read sequence
	// ====================

	always_ff @(posedge master_clock or negedge core_resetn) begin
		if (!core_resetn) begin
			state <= st_idle;
			idx <= '0;
			ch <= 1'b0;
			info_q <= '0;
		end else begin
			case (state)
				st_idle: begin
					// buffers are free once the request is up
					if (huff_req) begin
						idx <= '0;
						ch <= 1'b0;
						state <= st_header;
					end
				end
				st_header: begin
					if (fifo_rd) begin
						info_q.mode <= mp3_dec_pkg::channel_mode_e'(
							fifo_data[`MP3_HDR_MODE_MSB:`MP3_HDR_MODE_LSB]);
						info_q.ch1 <= mp3_dec_pkg::side_info_t'(
							fifo_data[`MP3_HDR_CH1_LSB +: $bits(mp3_dec_pkg::side_info_t)]);
						info_q.ch0 <= mp3_dec_pkg::side_info_t'(
							fifo_data[`MP3_HDR_CH0_LSB +: $bits(mp3_dec_pkg::side_info_t)]);
						state <= st_samples;
					end
				end
				st_samples: begin
					// empty fifo just holds everything in place
					if (fifo_rd) begin
						if (last_word) begin
							state <= st_ack;
						end else if (!ch && two_ch) begin
							ch <= 1'b1;
						end else begin
							ch <= 1'b0;
							idx <= idx + 1'b1;
						end
					end
				end
				st_ack: begin
					// hold ack and info until the request drops
					if (!huff_req) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// the external fifo is never popped while empty
	a_no_empty_read: assert property (
		@(posedge master_clock) disable iff (!core_resetn)
		fifo_rd |-> !fifo_empty
	);

endmodule

// File: design/granule_ram.sv
// Channel sample buffer
`include "mp3_dec_defines.svh"

module granule_ram (
	input  logic                        master_clock,
	input  logic                        we,
	input  logic                        rd_en,
	input  logic [`MP3_ADDR_WIDTH-1:0]  wr_addr,
	input  logic [`MP3_ADDR_WIDTH-1:0]  rd_addr,
	input  logic [`MP3_DATA_WIDTH-1:0]  wr_data,
	output logic [`MP3_DATA_WIDTH-1:0]  rd_data
);

	// one granule of one channel
	logic [`MP3_DATA_WIDTH-1:0] mem [0:`MP3_GRANULE_LEN-1];

	// ====================
	// write port
	// ====================

	// filled by the reader during the huffman stage
	always_ff @(posedge master_clock) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// ====================
	// read port
	// ====================

	// registered read, output holds while rd_en is low
	always_ff @(posedge master_clock) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: design/granule_sequencer.sv
// Granule stage sequencer
module granule_sequencer (
	input  logic                        master_clock,
	input  logic                        core_resetn,
	input  logic                        huff_ack,
	input  logic                        mac_ack,
	input  mp3_dec_pkg::granule_info_t  huff_info,
	output logic                        huff_req,
	output logic                        mac_req,
	output mp3_dec_pkg::granule_info_t  mac_info
);

	// three stages, one granule at a time
	typedef enum logic [1:0] {
		stage_init,
		stage_huff,
		stage_mac
	} stage_e;

	stage_e stage;

	// ====================
	// stage machine
	// ====================

	always_ff @(posedge master_clock or negedge core_resetn) begin
		if (!core_resetn) begin
			stage <= stage_init;
			huff_req <= 1'b0;
			mac_req <= 1'b0;
			mac_info <= '0;
		end else begin
			case (stage)
				stage_init: begin
					// both previous handshakes fully closed
					// buffers free for the next granule
					if (!huff_ack && !mac_ack) begin
						huff_req <= 1'b1;
						stage <= stage_huff;
					end
				end
				stage_huff: begin
					// reader has the whole granule in the buffers
					if (huff_ack) begin
						// header info held for the whole mac stage
						mac_info <= huff_info;
						huff_req <= 1'b0;
						// mode in mac_info selects channel 1 in the stage
						mac_req <= 1'b1;
						stage <= stage_mac;
					end
				end
				stage_mac: begin
					// last pcm word accepted downstream
					if (mac_ack) begin
						mac_req <= 1'b0;
						stage <= stage_init;
					end
				end
				default: begin
					huff_req <= 1'b0;
					mac_req <= 1'b0;
					stage <= stage_init;
				end
			endcase
		end
	end

	// ====================
	// checks
	// ====================

	// buffers are owned by one stage at a time
	a_one_owner: assert property (
		@(posedge master_clock) disable iff (!core_resetn)
		!(huff_req && mac_req)
	);

endmodule

// File: design/mac_stage.sv
// MAC output stage
`include "mp3_dec_defines.svh"

module mac_stage (
	input  logic                          master_clock,
	input  logic                          core_resetn,
	input  logic                          mac_req,
	input  logic                          pcm_ready,
	input  mp3_dec_pkg::granule_info_t    info,
	input  logic [`MP3_DATA_WIDTH-1:0]    ch0_data,
	input  logic [`MP3_DATA_WIDTH-1:0]    ch1_data,
	output logic [`MP3_ADDR_WIDTH-1:0]    rd_addr,
	output logic                          ch0_rd_en,
	output logic                          ch1_rd_en,
	output logic                          pcm_valid,
	output logic                          mac_ack,
	output mp3_dec_pkg::pcm_word_t        pcm
);

	localparam logic [`MP3_ADDR_WIDTH-1:0] last_idx = `MP3_ADDR_WIDTH'(`MP3_GRANULE_LEN - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_out,
		st_done
	} mac_state_e;

	mac_state_e                  state;
	logic [`MP3_ADDR_WIDTH-1:0]  idx;
	logic                        ch;
	logic                        two_ch;
	logic                        last_word;

	// channel 1 is only played for stereo and joint stereo
	assign two_ch = (info.mode == mp3_dec_pkg::stereo) ||
		(info.mode == mp3_dec_pkg::joint_stereo);
	assign last_word = (idx == last_idx) && (ch || !two_ch);

	// one read cycle per word, buffers idle otherwise
	assign rd_addr = idx;
	assign ch0_rd_en = (state == st_read) && !ch;
	assign ch1_rd_en = (state == st_read) && ch;
	assign pcm_valid = (state == st_out);
	assign mac_ack = (state == st_done);

	// ram output holds while waiting, so the word stays put
	always_comb begin
		pcm.channel = ch;
		pcm.index = idx;
		pcm.info = ch ? info.ch1 : info.ch0;
		pcm.sample = ch ? ch1_data : ch0_data;
	end

	always_ff @(posedge master_clock or negedge core_resetn) begin
		if (!core_resetn) begin
			state <= st_idle;
			idx <= '0;
			ch <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (mac_req) begin
						idx <= '0;
						ch <= 1'b0;
						state <= st_read;
					end
				end
				// data valid one edge after the read
				st_read: state <= st_out;
				st_out: begin
					// stalled words wait here for ready
					if (pcm_ready) begin
						if (last_word) begin
							state <= st_done;
						end else begin
							if (!ch && two_ch) begin
								ch <= 1'b1;
							end else begin
								ch <= 1'b0;
								idx <= idx + 1'b1;
							end
							state <= st_read;
						end
					end
				end
				st_done: begin
					if (!mac_req) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// a stalled word is held unchanged until it is taken
	a_pcm_hold: assert property (
		@(posedge master_clock) disable iff (!core_resetn)
		pcm_valid && !pcm_ready |=> pcm_valid && $stable(pcm)
	);

endmodule

// File: design/mp3_dec_top.sv
// MP3 granule decoder top
`include "mp3_dec_defines.svh"

module mp3_dec_top (
	input  logic                        master_clock,
	input  logic                        MAC_resetn,
	input  logic                        module_en,
	input  logic                        fifo_empty,
	input  logic [`MP3_DATA_WIDTH-1:0]  fifo_data,
	output logic                        fifo_rd,
	input  logic                        pcm_ready,
	output logic                        pcm_valid,
	output mp3_dec_pkg::pcm_word_t      pcm
);

	logic                        core_resetn;
	// stage handshakes
	logic                        huff_req;
	logic                        huff_ack;
	logic                        mac_req;
	logic                        mac_ack;
	mp3_dec_pkg::granule_info_t  huff_info;
	mp3_dec_pkg::granule_info_t  mac_info;
	// buffer ports
	mp3_dec_pkg::buf_write_t     buf_wr;
	logic [`MP3_ADDR_WIDTH-1:0]  rd_addr;
	logic                        ch0_rd_en;
	logic                        ch1_rd_en;
	logic [`MP3_DATA_WIDTH-1:0]  ch0_data;
	logic [`MP3_DATA_WIDTH-1:0]  ch1_data;

	reset_sequencer i_reset_sequencer (
		.master_clock(master_clock), .MAC_resetn(MAC_resetn),
		.module_en(module_en), .core_resetn(core_resetn)
	);

	huff_stream_reader i_huff_stream_reader (
		.master_clock(master_clock), .core_resetn(core_resetn),
		.fifo_empty(fifo_empty), .fifo_data(fifo_data), .fifo_rd(fifo_rd),
		.huff_req(huff_req), .huff_ack(huff_ack), .info(huff_info), .buf_wr(buf_wr)
	);

	granule_sequencer i_granule_sequencer (
		.master_clock(master_clock), .core_resetn(core_resetn),
		.huff_ack(huff_ack), .mac_ack(mac_ack), .huff_info(huff_info),
		.huff_req(huff_req), .mac_req(mac_req), .mac_info(mac_info)
	);

	// one buffer per channel, shared write bus and read address
	granule_ram i_ch0_ram (
		.master_clock(master_clock), .we(buf_wr.ch0_we), .rd_en(ch0_rd_en),
		.wr_addr(buf_wr.addr), .rd_addr(rd_addr), .wr_data(buf_wr.data), .rd_data(ch0_data)
	);

	granule_ram i_ch1_ram (
		.master_clock(master_clock), .we(buf_wr.ch1_we), .rd_en(ch1_rd_en),
		.wr_addr(buf_wr.addr), .rd_addr(rd_addr), .wr_data(buf_wr.data), .rd_data(ch1_data)
	);

	mac_stage i_mac_stage (
		.master_clock(master_clock), .core_resetn(core_resetn),
		.mac_req(mac_req), .pcm_ready(pcm_ready), .info(mac_info),
		.ch0_data(ch0_data), .ch1_data(ch1_data), .rd_addr(rd_addr),
		.ch0_rd_en(ch0_rd_en), .ch1_rd_en(ch1_rd_en),
		.pcm_valid(pcm_valid), .mac_ack(mac_ack), .pcm(pcm)
	);

endmodule

// File: sim/tb_mp3_dec.sv
// MP3 decoder testbench
`include "mp3_dec_defines.svh"

module tb_mp3_dec;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_tests = 6;
	// cycles held with module_en low
	localparam int gap_cycles = 12;

	// one row of the stimulus table
	typedef struct packed {
		mp3_dec_pkg::channel_mode_e  mode;
		mp3_dec_pkg::side_info_t     ch0;
		mp3_dec_pkg::side_info_t     ch1;
		logic [`MP3_DATA_WIDTH-1:0]  base;
		logic                        en_gap;
	} test_row_t;

	logic                        master_clock = 1'b0;
	logic                        MAC_resetn;
	logic                        module_en;
	logic                        fifo_empty;
	logic [`MP3_DATA_WIDTH-1:0]  fifo_data;
	logic                        fifo_rd;
	logic                        pcm_ready;
	logic                        pcm_valid;
	mp3_dec_pkg::pcm_word_t      pcm;

	test_row_t                   rows [num_tests];
	string                       names [num_tests];
	// fifo model contents and predicted pcm words
	logic [`MP3_DATA_WIDTH-1:0]  fifo_q [$];
	mp3_dec_pkg::pcm_word_t      exp_q [$];
	mp3_dec_pkg::pcm_word_t      exp_word;
	mp3_dec_pkg::pcm_word_t      held_word;
	logic                        stall_prev = 1'b0;
	string                       cur_name = "reset";
	integer                      seed;
	int                          err_count = 0;
	int                          word_count = 0;
	int                          cycle_count = 0;
	int                          timeout_limit = 0;
	int                          total_words;

	mp3_dec_top i_mp3_dec_top (
		.master_clock(master_clock), .MAC_resetn(MAC_resetn), .module_en(module_en),
		.fifo_empty(fifo_empty), .fifo_data(fifo_data), .fifo_rd(fifo_rd),
		.pcm_ready(pcm_ready), .pcm_valid(pcm_valid), .pcm(pcm)
	);

	// 40 ns period
	initial begin
		forever #20 master_clock = ~master_clock;
	end

	// ====================
	// stimulus table
	// ====================

	function automatic test_row_t make_row(input logic [1:0] mode, input logic [3:0] ch0,
		input logic [3:0] ch1, input logic [15:0] base, input logic en_gap);
		test_row_t row;
		row.mode = mp3_dec_pkg::channel_mode_e'(mode);
		row.ch0 = mp3_dec_pkg::side_info_t'(ch0);
		row.ch1 = mp3_dec_pkg::side_info_t'(ch1);
		row.base = base;
		row.en_gap = en_gap;
		return row;
	endfunction

	// stereo and joint stereo carry channel 1 words
	function automatic logic has_ch1(input test_row_t row);
		return (row.mode == mp3_dec_pkg::stereo) || (row.mode == mp3_dec_pkg::joint_stereo);
	endfunction

	// header plus samples of one granule
	function automatic int stream_words(input test_row_t row);
		return 1 + `MP3_GRANULE_LEN * (has_ch1(row) ? 2 : 1);
	endfunction

	// side info differs per channel and per granule
	task automatic fill_table();
		rows[0] = make_row(2'd0, 4'h9, 4'h6, 16'h1000, 1'b0);
		names[0] = "stereo_basic";
		rows[1] = make_row(2'd1, 4'h3, 4'hc, 16'h2100, 1'b0);
		names[1] = "joint_stereo";
		rows[2] = make_row(2'd2, 4'he, 4'h1, 16'h3200, 1'b0);
		names[2] = "dual_channel";
		rows[3] = make_row(2'd3, 4'h5, 4'ha, 16'h4300, 1'b0);
		names[3] = "mono";
		rows[4] = make_row(2'd0, 4'hb, 4'h4, 16'h5400, 1'b1);
		names[4] = "stereo_after_disable";
		rows[5] = make_row(2'd3, 4'h7, 4'h8, 16'h6500, 1'b1);
		names[5] = "mono_after_disable";
	endtask

	// header word, then interleaved samples, with the predicted output
	task automatic load_granule(input test_row_t row);
		logic [`MP3_DATA_WIDTH-1:0] hdr;
		mp3_dec_pkg::pcm_word_t     word;
		hdr = '0;
		hdr[`MP3_HDR_MODE_MSB:`MP3_HDR_MODE_LSB] = row.mode;
		hdr[`MP3_HDR_CH1_LSB +: 4] = row.ch1;
		hdr[`MP3_HDR_CH0_LSB +: 4] = row.ch0;
		fifo_q.push_back(hdr);
		for (int i = 0; i < `MP3_GRANULE_LEN; i++) begin
			word.channel = 1'b0;
			word.index = `MP3_ADDR_WIDTH'(i);
			word.info = row.ch0;
			word.sample = row.base + 16'(i);
			fifo_q.push_back(word.sample);
			exp_q.push_back(word);
			// channel 1 sits 256 above channel 0
			if (has_ch1(row)) begin
				word.channel = 1'b1;
				word.info = row.ch1;
				word.sample = row.base + 16'(i) + 16'd256;
				fifo_q.push_back(word.sample);
				exp_q.push_back(word);
			end
		end
	endtask

	// ====================
	// fifo model and ready
	// ====================

	// one process owns the seed, so the random sequence is fixed
	always @(posedge master_clock) begin
		if (fifo_rd) begin
			if (fifo_q.size() == 0) begin
				$display("fifo_rd while the FIFO model is empty in test %s", cur_name);
				err_count++;
			end else begin
				void'(fifo_q.pop_front());
			end
		end
		// about one cycle in four shows an empty fifo
		if ((fifo_q.size() == 0) || (($random(seed) & 32'h3) == 0)) begin
			fifo_empty <= 1'b1;
		end else begin
			fifo_empty <= 1'b0;
		end
		if (fifo_q.size() != 0) begin
			fifo_data <= fifo_q[0];
		end
		pcm_ready <= (($random(seed) & 32'h3) != 0);
	end

	// ====================
	// scoreboard
	// ====================

	always @(posedge master_clock) begin
		if (MAC_resetn) begin
			// a stalled word must stay put
			if (stall_prev) begin
				if (!pcm_valid) begin
					$display("pcm_valid dropped before the word was taken in test %s", cur_name);
					err_count++;
				end else if (pcm !== held_word) begin
					$display("CHECK FAILED %s: stalled pcm expected %h actual %h",
						cur_name, held_word, pcm);
					err_count++;
				end
			end
			if (pcm_valid && pcm_ready) begin
				if (exp_q.size() == 0) begin
					$display("unexpected PCM word %h in test %s", pcm, cur_name);
					err_count++;
				end else begin
					exp_word = exp_q.pop_front();
					if (pcm !== exp_word) begin
						$display("CHECK FAILED %s: pcm expected %h actual %h",
							cur_name, exp_word, pcm);
						err_count++;
					end
					word_count++;
				end
			end
			stall_prev = pcm_valid && !pcm_ready;
			held_word = pcm;
		end
	end

	// limit from the table length
	always @(posedge master_clock) begin
		cycle_count++;
		if ((timeout_limit != 0) && (cycle_count >= timeout_limit)) begin
			$display("timeout after %0d cycles in test %s, DUT stopped producing words",
				cycle_count, cur_name);
			$display("TB FAILED");
			$finish;
		end
	end

	// ====================
	// test sequence
	// ====================

	task automatic run_test(input int t);
		int start_err;
		int start_words;
		start_err = err_count;
		start_words = word_count;
		cur_name = names[t];
		if (rows[t].en_gap) begin
			@(posedge master_clock);
			module_en <= 1'b0;
			// core reset is in by now
			repeat (2) @(posedge master_clock);
			@(negedge master_clock);
			load_granule(rows[t]);
			// words waiting, yet the core stays quiet
			repeat (gap_cycles) begin
				@(posedge master_clock);
				if (fifo_rd || pcm_valid) begin
					$display("fifo_rd or pcm_valid active with module_en low in test %s",
						cur_name);
					err_count++;
				end
			end
			module_en <= 1'b1;
		end else begin
			@(negedge master_clock);
			load_granule(rows[t]);
		end
		while (exp_q.size() != 0) begin
			@(negedge master_clock);
		end
		if (fifo_q.size() != 0) begin
			$display("%0d stream words left unread in test %s", fifo_q.size(), cur_name);
			err_count++;
		end
		if (err_count == start_err) begin
			$display("test %s: ok, %0d words", cur_name, word_count - start_words);
		end else begin
			$display("test %s: %0d errors", cur_name, err_count - start_err);
		end
	endtask

	initial begin
		seed = 32'h8f839e9d;
		MAC_resetn = 1'b0;
		module_en = 1'b1;
		fifo_empty = 1'b1;
		fifo_data = '0;
		pcm_ready = 1'b0;
		fill_table();
		total_words = 0;
		for (int t = 0; t < num_tests; t++) begin
			total_words += stream_words(rows[t]);
		end
		timeout_limit = 40 * total_words + 400;
		repeat (8) @(posedge master_clock);
		// outputs idle under reset
		if (fifo_rd || pcm_valid) begin
			$display("fifo_rd or pcm_valid high during reset");
			err_count++;
		end
		MAC_resetn <= 1'b1;
		for (int t = 0; t < num_tests; t++) begin
			run_test(t);
		end
		// quiet tail, a duplicate word would show up here
		repeat (8) @(negedge master_clock);
		$display("tests %0d, words checked %0d, errors %0d", num_tests, word_count, err_count);
		if (err_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: mp3_dec.f
+incdir+design
design/mp3_dec_pkg.sv
design/reset_sequencer.sv
design/huff_stream_reader.sv
design/granule_ram.sv
design/granule_sequencer.sv
design/mac_stage.sv
design/mp3_dec_top.sv
sim/tb_mp3_dec.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the MP3 decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_mp3_dec -f mp3_dec.f -o tb_mp3_dec

./obj_dir/tb_mp3_dec > sim.log 2>&1
cat sim.log

# the run counts only with the pass line in the log
if grep -qx "TB PASSED" sim.log; then
	echo "simulation ok"
else
	echo "simulation failed"
	exit 1
fi
